// File: hw/vga_debug_pkg.sv
package vga_debug_pkg;

  // raster for 1368x768 active inside a 1800x795 frame
  localparam int pos_w = 11;

  localparam logic [pos_w-1:0] h_active_end = 11'd1367;
  localparam logic [pos_w-1:0] h_sync_start = 11'd1439;
  localparam logic [pos_w-1:0] h_sync_end   = 11'd1583;
  localparam logic [pos_w-1:0] h_line_end   = 11'd1799;

  localparam logic [pos_w-1:0] v_active_end = 11'd767;
  localparam logic [pos_w-1:0] v_sync_start = 11'd768;
  localparam logic [pos_w-1:0] v_sync_end   = 11'd771;
  localparam logic [pos_w-1:0] v_frame_end  = 11'd794;

  // text grid, one row per 16 scan lines
  localparam int glyph_w = 8;
  localparam int glyph_h = 16;
  localparam int row_w   = pos_w - 4;

  localparam logic [row_w-1:0] text_rows   = 7'd46;
  localparam logic [row_w-1:0] reg_rows    = 7'd32;
  localparam logic [pos_w-1:0] text_bottom = 11'd735;

  // pane start columns, each pane is 32 digits of 8 pixels
  localparam logic [pos_w-1:0] pane_x0    = 11'd16;
  localparam logic [pos_w-1:0] pane_x1    = 11'd280;
  localparam logic [pos_w-1:0] pane_x2    = 11'd552;
  localparam logic [pos_w-1:0] pane_x3    = 11'd824;
  localparam logic [pos_w-1:0] pane_x4    = 11'd1088;
  localparam logic [pos_w-1:0] pane_width = 11'd256;

  localparam logic [2:0] pane_instr_even = 3'd0;
  localparam logic [2:0] pane_instr_odd  = 3'd1;
  localparam logic [2:0] pane_reg        = 3'd2;
  localparam logic [2:0] pane_data_even  = 3'd3;
  localparam logic [2:0] pane_data_odd   = 3'd4;

  localparam logic [3:0] bg_r = 4'd5;
  localparam logic [3:0] bg_g = 4'd3;
  localparam logic [3:0] bg_b = 4'd7;
  localparam logic [3:0] fg_r = 4'd15;
  localparam logic [3:0] fg_g = 4'd15;
  localparam logic [3:0] fg_b = 4'd15;

  localparam int mem_words = 92;
  localparam int mem_aw    = 7;  // enough for mem_words

  // bit c lights glyph column c, so the drawing reads mirrored
  localparam logic [glyph_w-1:0] glyph_one [glyph_h] = '{
    8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0001_1100,
    8'b0001_1010, 8'b0001_1000, 8'b0001_1000, 8'b0001_1000,
    8'b0001_1000, 8'b0001_1000, 8'b0001_1000, 8'b0001_1000,
    8'b0111_1110, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000
  };

  localparam logic [glyph_w-1:0] glyph_zero [glyph_h] = '{
    8'b0000_0000, 8'b0000_0000, 8'b0011_1100, 8'b0110_0110,
    8'b0110_0110, 8'b0110_0110, 8'b0110_0110, 8'b0110_0110,
    8'b0110_0110, 8'b0110_0110, 8'b0110_0110, 8'b0110_0110,
    8'b0011_1100, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000
  };

  // one text row, fields in pane order from the msb down
  typedef struct packed {
    logic [31:0] instr_even;
    logic [31:0] instr_odd;
    logic [31:0] reg_word;
    logic [31:0] data_even;
    logic [31:0] data_odd;
  } row_words_t;

  typedef union packed {
    logic [159:0] flat;
    row_words_t   words;
  } row_word_u;

endpackage

// File: hw/scan_if.sv
`timescale 1ns/100ps

// raster position and sync levels of the current pixel
interface scan_if;
  import vga_debug_pkg::*;

  logic [pos_w-1:0] sx;
  logic [pos_w-1:0] sy;
  logic             de;
  logic             hsync;  // active low
  logic             vsync;  // active low

  modport src (
    output sx,
    output sy,
    output de,
    output hsync,
    output vsync
  );

  modport mon (
    input sx,
    input sy,
    input de,
    input hsync,
    input vsync
  );

endinterface

// File: hw/pane_if.sv
`timescale 1ns/100ps

// what the decoder found under the current pixel
interface pane_if;

  logic [2:0] pane;       // pane code
  logic [4:0] bit_sel;    // digit bit, 31 is leftmost
  logic [3:0] glyph_row;
  logic [2:0] glyph_col;
  logic       bg;         // no digit here

  modport src (
    output pane,
    output bit_sel,
    output glyph_row,
    output glyph_col,
    output bg
  );

  modport dst (
    input pane,
    input bit_sel,
    input glyph_row,
    input glyph_col,
    input bg
  );

endinterface

// File: hw/scan_timing.sv
`timescale 1ns/100ps

module scan_timing (
  input logic clk,
  input logic rst,
  scan_if.src scan
);
  import vga_debug_pkg::*;

  logic [pos_w-1:0] sx;
  logic [pos_w-1:0] sy;
  logic             in_hsync;
  logic             in_vsync;

  // free running raster counters
  always_ff @(posedge clk) begin
    if (rst) begin
      sx <= '0;
      sy <= '0;
    end else if (sx == h_line_end) begin
      sx <= '0;
      sy <= (sy == v_frame_end) ? '0 : sy + 1'b1;  // wrap at end of frame
    end else begin
      sx <= sx + 1'b1;
    end
  end

  assign in_hsync = (sx > h_sync_start) && (sx <= h_sync_end);  // pixels 1440 to 1583
  assign in_vsync = (sy >= v_sync_start) && (sy < v_sync_end);

  assign scan.sx    = sx;
  assign scan.sy    = sy;
  assign scan.de    = (sx <= h_active_end) && (sy <= v_active_end);
  assign scan.hsync = ~in_hsync;  // negative polarity
  assign scan.vsync = ~in_vsync;

  // counters stay inside the frame
  sx_in_line: assert property (
    @(posedge clk) disable iff (rst)
    sx <= h_line_end
  ) else $error("sx beyond end of line: %0d", sx);

  sy_in_frame: assert property (
    @(posedge clk) disable iff (rst)
    sy <= v_frame_end
  ) else $error("sy beyond end of frame: %0d", sy);

endmodule

// File: hw/pane_decoder.sv
`timescale 1ns/100ps

module pane_decoder (
  scan_if.mon scan,
  pane_if.src pane
);
  import vga_debug_pkg::*;

  logic [2:0]       pane_sel;
  logic [pos_w-1:0] dx;        // offset into the selected pane
  logic             in_pane;
  logic [row_w-1:0] text_row;
  logic             reg_blank;

  function automatic logic hit(input logic [pos_w-1:0] x, input logic [pos_w-1:0] x0);
    return (x >= x0) && (x < x0 + pane_width);
  endfunction

  always_comb begin
    pane_sel = pane_instr_even;
    dx       = '0;
    in_pane  = 1'b1;
    if (hit(scan.sx, pane_x0)) begin
      pane_sel = pane_instr_even;
      dx       = scan.sx - pane_x0;
    end else if (hit(scan.sx, pane_x1)) begin
      pane_sel = pane_instr_odd;
      dx       = scan.sx - pane_x1;
    end else if (hit(scan.sx, pane_x2)) begin
      pane_sel = pane_reg;
      dx       = scan.sx - pane_x2;
    end else if (hit(scan.sx, pane_x3)) begin
      pane_sel = pane_data_even;
      dx       = scan.sx - pane_x3;
    end else if (hit(scan.sx, pane_x4)) begin
      pane_sel = pane_data_odd;
      dx       = scan.sx - pane_x4;
    end else begin
      in_pane = 1'b0;  // margin or gap
    end
  end

  assign text_row  = scan.sy[pos_w-1:4];
  assign reg_blank = (pane_sel == pane_reg) && (text_row >= reg_rows);

  assign pane.pane      = pane_sel;
  assign pane.bit_sel   = 5'd31 - dx[7:3];  // msb drawn first
  assign pane.glyph_row = scan.sy[3:0];
  assign pane.glyph_col = scan.sx[2:0];     // panes start on 8 pixel columns

  assign pane.bg = !scan.de || (scan.sy > text_bottom) || !in_pane || reg_blank;

endmodule

// File: hw/snoop_ram.sv
`timescale 1ns/100ps

module snoop_ram (
  input  logic                     clk,
  scan_if.mon                      scan,
  input  logic [31:0]              reg_data,
  input  logic [4:0]               reg_addr,
  input  logic                     reg_en,
  input  logic [31:0]              instr_data,
  input  logic [31:0]              instr_addr,
  input  logic                     instr_en,
  input  logic [31:0]              data_data,
  input  logic [31:0]              data_addr,
  input  logic                     data_en,
  output vga_debug_pkg::row_word_u row
);
  import vga_debug_pkg::*;

  logic [31:0] reg_mem   [32];
  logic [31:0] instr_mem [mem_words];
  logic [31:0] data_mem  [mem_words];

  logic              instr_hit;
  logic              data_hit;
  logic [row_w-1:0]  text_row;
  logic [mem_aw-1:0] word_even;
  logic [mem_aw-1:0] word_odd;
  row_word_u         row_d;

  // shadow copies start cleared, like the cpu after power up
  initial begin
    for (int i = 0; i < 32; i++) begin
      reg_mem[i] = '0;
    end
    for (int i = 0; i < mem_words; i++) begin
      instr_mem[i] = '0;
      data_mem[i]  = '0;
    end
  end

  // byte addresses, word index is addr/4
  assign instr_hit = instr_en && (instr_addr[31:2] < 30'(mem_words));
  assign data_hit  = data_en && (data_addr[31:2] < 30'(mem_words));

  always_ff @(posedge clk) begin
    if (reg_en)
      reg_mem[reg_addr] <= reg_data;
    if (instr_hit)
      instr_mem[instr_addr[mem_aw+1:2]] <= instr_data;
    if (data_hit)
      data_mem[data_addr[mem_aw+1:2]] <= data_data;
  end

  assign text_row  = scan.sy[pos_w-1:4];            // sy/16
  assign word_even = {text_row[mem_aw-2:0], 1'b0};
  assign word_odd  = {text_row[mem_aw-2:0], 1'b1};

  always_comb begin
    row_d.flat = '0;  // rows past the grid stay blank
    if (text_row < text_rows) begin
      row_d.words.instr_even = instr_mem[word_even];
      row_d.words.instr_odd  = instr_mem[word_odd];
      row_d.words.data_even  = data_mem[word_even];
      row_d.words.data_odd   = data_mem[word_odd];
    end
    if (text_row < reg_rows)
      row_d.words.reg_word = reg_mem[text_row[4:0]];
  end

  // reads see the old contents on a same-edge write
  always_ff @(posedge clk) begin
    row <= row_d;
  end

  snoop_en_known: assert property (
    @(posedge clk) !$isunknown({reg_en, instr_en, data_en})
  ) else $error("snoop enable is X");

endmodule

// File: hw/pixel_shader.sv
`timescale 1ns/100ps

module pixel_shader (
  input  logic                            clk,
  input  logic                            rst,
  scan_if.mon                             scan,
  pane_if.dst                             pane,
  input  vga_debug_pkg::row_word_u        row,
  output logic [3:0]                      vga_r,
  output logic [3:0]                      vga_g,
  output logic [3:0]                      vga_b,
  output logic                            vga_hsync,
  output logic                            vga_vsync,
  output logic [vga_debug_pkg::pos_w-1:0] cap_sx,
  output logic [vga_debug_pkg::pos_w-1:0] cap_sy,
  output logic                            cap_de
);
  import vga_debug_pkg::*;

  // stage 1, lined up with the row coming out of snoop_ram
  logic [pos_w-1:0]   sx1;
  logic [pos_w-1:0]   sy1;
  logic               de1, hs1, vs1, bg1;
  logic [2:0]         pane1;
  logic [4:0]         bit1;
  logic [3:0]         grow1;
  logic [2:0]         gcol1;

  logic [31:0]        word;
  logic               digit;
  logic [glyph_w-1:0] glyph_line;
  logic               lit;

  always_ff @(posedge clk) begin
    if (rst) begin
      sx1 <= '0;
      sy1 <= '0;
      de1 <= 1'b0;
      hs1 <= 1'b1;
      vs1 <= 1'b1;
      bg1 <= 1'b1;
      pane1 <= '0;
      bit1  <= '0;
      grow1 <= '0;
      gcol1 <= '0;
    end else begin
      sx1 <= scan.sx;
      sy1 <= scan.sy;
      de1 <= scan.de;
      hs1 <= scan.hsync;
      vs1 <= scan.vsync;
      bg1 <= pane.bg;
      pane1 <= pane.pane;
      bit1  <= pane.bit_sel;
      grow1 <= pane.glyph_row;
      gcol1 <= pane.glyph_col;
    end
  end

  always_comb begin
    case (pane1)
      pane_instr_even: word = row.words.instr_even;
      pane_instr_odd:  word = row.words.instr_odd;
      pane_reg:        word = row.words.reg_word;
      pane_data_even:  word = row.words.data_even;
      pane_data_odd:   word = row.words.data_odd;
      default:         word = '0;
    endcase
  end

  assign digit      = word[bit1];
  assign glyph_line = digit ? glyph_one[grow1] : glyph_zero[grow1];
  assign lit        = !bg1 && glyph_line[gcol1];

  // stage 2 output registers
  always_ff @(posedge clk) begin
    if (rst) begin
      {vga_r, vga_g, vga_b} <= {bg_r, bg_g, bg_b};
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      cap_sx <= '0;
      cap_sy <= '0;
      cap_de <= 1'b0;
    end else begin
      {vga_r, vga_g, vga_b} <= lit ? {fg_r, fg_g, fg_b} : {bg_r, bg_g, bg_b};
      vga_hsync <= hs1;
      vga_vsync <= vs1;
      cap_sx <= sx1;
      cap_sy <= sy1;
      cap_de <= de1;
    end
  end

  // blanking from the counters must reach the colour two clocks later
  blank_is_bg: assert property (
    @(posedge clk) disable iff (rst)
    !cap_de |-> ({vga_r, vga_g, vga_b} == {bg_r, bg_g, bg_b})
  ) else $error("colour not background while de low");

  row_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(row.flat)
  ) else $error("shadow row has X bits");

endmodule

// File: hw/vga_debug_top.sv
`timescale 1ns/100ps

module vga_debug_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [31:0]                     reg_data,
  input  logic [4:0]                      reg_addr,
  input  logic                            reg_en,
  input  logic [31:0]                     instr_data,
  input  logic [31:0]                     instr_addr,
  input  logic                            instr_en,
  input  logic [31:0]                     data_data,
  input  logic [31:0]                     data_addr,
  input  logic                            data_en,
  output logic [3:0]                      vga_r,
  output logic [3:0]                      vga_g,
  output logic [3:0]                      vga_b,
  output logic                            vga_hsync,
  output logic                            vga_vsync,
  output logic [vga_debug_pkg::pos_w-1:0] cap_sx,  // frame grabber position
  output logic [vga_debug_pkg::pos_w-1:0] cap_sy,
  output logic                            cap_de
);
  import vga_debug_pkg::*;

  row_word_u row;

  scan_if scan ();
  pane_if pane ();

  scan_timing u_timing (
    .clk  (clk),
    .rst  (rst),
    .scan (scan.src)
  );

  pane_decoder u_decoder (
    .scan (scan.mon),
    .pane (pane.src)
  );

  snoop_ram u_ram (
    .clk        (clk),
    .scan       (scan.mon),
    .reg_data   (reg_data),
    .reg_addr   (reg_addr),
    .reg_en     (reg_en),
    .instr_data (instr_data),
    .instr_addr (instr_addr),
    .instr_en   (instr_en),
    .data_data  (data_data),
    .data_addr  (data_addr),
    .data_en    (data_en),
    .row        (row)
  );

  pixel_shader u_shader (
    .clk       (clk),
    .rst       (rst),
    .scan      (scan.mon),
    .pane      (pane.dst),
    .row       (row),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .cap_sx    (cap_sx),
    .cap_sy    (cap_sy),
    .cap_de    (cap_de)
  );

endmodule

// File: tests/tb_vga_debug.sv
`timescale 1ns/100ps

module tb_vga_debug;

  // raster and layout numbers of the monitor
  localparam int line_len    = 1800;
  localparam int frame_len   = 795;
  localparam int cycle_limit = 3 * line_len * frame_len;
  localparam int n_words     = 92;
  localparam logic [11:0] bg_rgb = 12'h537;
  localparam logic [11:0] fg_rgb = 12'hfff;

  localparam int pane_left [5] = '{16, 280, 552, 824, 1088};

  // bit c is glyph column c
  localparam logic [7:0] one_rows [16] = '{
    8'h00, 8'h00, 8'h18, 8'h1c, 8'h1a, 8'h18, 8'h18, 8'h18,
    8'h18, 8'h18, 8'h18, 8'h18, 8'h7e, 8'h00, 8'h00, 8'h00
  };
  localparam logic [7:0] zero_rows [16] = '{
    8'h00, 8'h00, 8'h3c, 8'h66, 8'h66, 8'h66, 8'h66, 8'h66,
    8'h66, 8'h66, 8'h66, 8'h66, 8'h3c, 8'h00, 8'h00, 8'h00
  };

  typedef struct packed {
    logic [11:0] rgb;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [10:0] sx;
    logic [10:0] sy;
  } pixel_t;

  localparam pixel_t reset_pixel = {bg_rgb, 1'b1, 1'b1, 1'b0, 11'd0, 11'd0};

  logic        clk;
  logic        rst;
  logic [31:0] reg_data = '0;
  logic [4:0]  reg_addr = '0;
  logic        reg_en = 1'b0;
  logic [31:0] instr_data = '0;
  logic [31:0] instr_addr = '0;
  logic        instr_en = 1'b0;
  logic [31:0] data_data = '0;
  logic [31:0] data_addr = '0;
  logic        data_en = 1'b0;
  logic [3:0]  vga_r;
  logic [3:0]  vga_g;
  logic [3:0]  vga_b;
  logic        vga_hsync;
  logic        vga_vsync;
  logic [10:0] cap_sx;
  logic [10:0] cap_sy;
  logic        cap_de;

  // shadow copies of the snooped words
  logic [31:0] reg_shadow [32];
  logic [31:0] instr_shadow [n_words];
  logic [31:0] data_shadow [n_words];

  int     m_sx = 0;
  int     m_sy = 0;
  int     frames_done = 0;
  int     cycle_count = 0;
  pixel_t exp_d1;
  pixel_t exp_d2;  // lines up with the DUT outputs

  vga_debug_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic pixel_t expected_pixel(input int x, input int y);
    pixel_t      p;
    int          pane;
    int          off;
    int          row;
    logic [31:0] word;
    logic [7:0]  glyph;
    logic        lit;
    pane = -1;
    off = 0;
    row = y / 16;
    p.sx = 11'(x);
    p.sy = 11'(y);
    p.hsync = !(x >= 1440 && x <= 1583);
    p.vsync = !(y >= 768 && y <= 770);
    p.de = (x < 1368) && (y < 768);
    for (int i = 0; i < 5; i++) begin
      if (x >= pane_left[i] && x < pane_left[i] + 256) begin
        pane = i;
        off = x - pane_left[i];
      end
    end
    lit = p.de && (y <= 735) && (pane >= 0) && !(pane == 2 && row >= 32);
    if (lit) begin
      case (pane)
        0:       word = instr_shadow[7'(2 * row)];
        1:       word = instr_shadow[7'(2 * row + 1)];
        2:       word = reg_shadow[5'(row)];
        3:       word = data_shadow[7'(2 * row)];
        default: word = data_shadow[7'(2 * row + 1)];
      endcase
      glyph = word[5'(31 - off / 8)] ? one_rows[4'(y % 16)] : zero_rows[4'(y % 16)];
      lit = glyph[3'(off % 8)];
    end
    p.rgb = lit ? fg_rgb : bg_rgb;
    return p;
  endfunction

  // a quarter of the word indices land past the shadowed range
  function automatic logic [31:0] random_byte_addr();
    logic [29:0] idx;
    if ($urandom_range(3) == 0) begin
      if ($urandom_range(1) == 0)
        idx = 30'(n_words + $urandom_range(163));  // includes aliases of low words
      else
        idx = 30'($urandom) | 30'h100;
    end else begin
      idx = 30'($urandom_range(n_words - 1));
    end
    return {idx, 2'($urandom)};
  endfunction

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch %s at sx=%0d sy=%0d: expected %0h, actual %0h",
               name, exp_d2.sx, exp_d2.sy, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "output check failed");
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      reg_en     <= ($urandom_range(7) == 0);
      reg_addr   <= 5'($urandom);
      reg_data   <= $urandom;
      instr_en   <= ($urandom_range(7) == 0);
      instr_addr <= random_byte_addr();
      instr_data <= $urandom;
      data_en    <= ($urandom_range(7) == 0);
      data_addr  <= random_byte_addr();
      data_data  <= $urandom;
    end
  end

  // reference model, snapshot taken before this edge's writes
  always @(posedge clk) begin
    if (rst) begin
      m_sx <= 0;
      m_sy <= 0;
      exp_d1 <= reset_pixel;
      exp_d2 <= reset_pixel;
      for (int i = 0; i < 32; i++)
        reg_shadow[i] = '0;
      for (int i = 0; i < n_words; i++) begin
        instr_shadow[i] = '0;
        data_shadow[i] = '0;
      end
    end else begin
      exp_d1 <= expected_pixel(m_sx, m_sy);
      exp_d2 <= exp_d1;
      if (reg_en)
        reg_shadow[reg_addr] = reg_data;
      if (instr_en && instr_addr[31:2] < 30'(n_words))
        instr_shadow[7'(instr_addr[31:2])] = instr_data;
      if (data_en && data_addr[31:2] < 30'(n_words))
        data_shadow[7'(data_addr[31:2])] = data_data;
      if (m_sx == line_len - 1) begin
        m_sx <= 0;
        if (m_sy == frame_len - 1) begin
          m_sy <= 0;
          frames_done <= frames_done + 1;
        end else begin
          m_sy <= m_sy + 1;
        end
      end else begin
        m_sx <= m_sx + 1;
      end
    end
  end

  always @(negedge clk) begin
    check_field("hsync", 32'(exp_d2.hsync), 32'(vga_hsync));
    check_field("vsync", 32'(exp_d2.vsync), 32'(vga_vsync));
    check_field("cap_sx", 32'(exp_d2.sx), 32'(cap_sx));
    check_field("cap_sy", 32'(exp_d2.sy), 32'(cap_sy));
    check_field("cap_de", 32'(exp_d2.de), 32'(cap_de));
    check_field("colour", 32'(exp_d2.rgb), 32'({vga_r, vga_g, vga_b}));
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: two frames did not complete within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(9547));
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    wait (frames_done == 2);
    repeat (3) @(posedge clk);  // drain the two stage pipeline
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: vga_debug.f
hw/vga_debug_pkg.sv
hw/scan_if.sv
hw/pane_if.sv
hw/scan_timing.sv
hw/pane_decoder.sv
hw/snoop_ram.sv
hw/pixel_shader.sv
hw/vga_debug_top.sv
tests/tb_vga_debug.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_vga_debug -f vga_debug.f -o sim_vga_debug

out=$(./obj_dir/sim_vga_debug 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
